// File: build.f
+incdir+hdl
hdl/i2c_pkg.sv
hdl/i2c_byte_shifter.sv
hdl/i2c_bit_engine.sv
hdl/i2c_sequencer.sv
hdl/i2c_master_top.sv
verification/i2c_slave_model.sv
verification/i2c_master_tb.sv

// File: verification/i2c_master_tb.sv
`include "i2c_defines.svh"

module i2c_master_tb;

	timeunit 1ns;
	timeprecision 1ns;

	localparam logic [6:0] DEV_ADDR = 7'h2a;
	localparam int TIMEOUT_CLKS = 200 * 4 * `I2C_QUARTER_CLKS;

	logic                   clk;
	logic                   rst_n;
	i2c_pkg::cmd_t          cmd;
	logic                   cmd_valid;
	logic [`I2C_BYTE_W-1:0] wr_data;
	logic                   wr_valid;
	logic                   wr_credit;
	logic [`I2C_BYTE_W-1:0] rd_data;
	logic                   rd_valid;
	logic                   done;
	logic                   scl;
	wire                    sda;

	logic [31:0] rng;
	logic [7:0]  shadow [256];
	logic [7:0]  shadow_ptr;
	logic [7:0]  exp_q [$];
	logic [7:0]  addr;
	int          len;
	int          err_cnt = 0;
	int          timeout_cnt = 0;
	int          credit_seen = 0;
	int          done_seen = 0;
	int          rd_seen = 0;
	int          scl_rises = 0;

	pullup (sda);

	i2c_master_top dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.wr_data   (wr_data),
		.wr_valid  (wr_valid),
		.wr_credit (wr_credit),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid),
		.done      (done),
		.scl       (scl),
		.sda       (sda)
	);

	i2c_slave_model #(.DEV_ADDR(DEV_ADDR)) slave_i (
		.scl (scl),
		.sda (sda)
	);

	always #50 clk = ~clk;

	function automatic logic [7:0] rand_byte();
		rng = rng * 32'd1103515245 + 32'd12345;
		return rng[23:16];
	endfunction

	// one byte at the shadow pointer, which then moves on
	function automatic logic [7:0] ref_byte(input logic is_write, input logic [7:0] wdata);
		logic [7:0] val;
		if (is_write)
			shadow[shadow_ptr] = wdata;
		val        = shadow[shadow_ptr];
		shadow_ptr = shadow_ptr + 8'd1;
		return val;
	endfunction

	task automatic log_error(input string msg);
		$display("** Error @ %0t ns: %s", $time, msg);
		err_cnt++;
	endtask

	always @(posedge clk) begin
		if (wr_credit === 1'b1)
			credit_seen++;
		if (done === 1'b1)
			done_seen++;
		if (rd_valid === 1'b1)
			rd_seen++;
	end

	always @(posedge scl)
		scl_rises++;

	// read data against the reference
	always @(posedge clk) begin
		if (rd_valid === 1'b1) begin
			assert (exp_q.size() != 0)
			else log_error($sformatf("rd_valid with no byte expected, data %02h", rd_data));
			if (exp_q.size() != 0) begin
				assert (rd_data === exp_q[0])
				else log_error($sformatf("read %02h, expected %02h", rd_data, exp_q[0]));
				void'(exp_q.pop_front());
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// waits and transfers
	//////////////////////////////////////////////////////////////////////

	task automatic wait_credit();
		int t;
		t = 0;
		while (wr_credit !== 1'b1 && t < TIMEOUT_CLKS) begin
			@(negedge clk);
			t++;
		end
		if (wr_credit !== 1'b1) begin
			$display("Timeout: the master never granted a write credit");
			timeout_cnt++;
		end
	endtask

	task automatic wait_done();
		int t;
		t = 0;
		while (done !== 1'b1 && t < TIMEOUT_CLKS) begin
			@(negedge clk);
			t++;
		end
		if (done !== 1'b1) begin
			$display("Timeout: the master never signalled done");
			timeout_cnt++;
		end
	endtask

	task automatic check_memory();
		for (int a = 0; a < 256; a++) begin
			assert (slave_i.mem[a] === shadow[a])
			else log_error($sformatf("slave byte %02h is %02h, expected %02h",
				a, slave_i.mem[a], shadow[a]));
		end
	endtask

	task automatic check_idle();
		for (int i = 0; i < 1000; i++) begin
			@(negedge clk);
			assert (scl === 1'b1 && sda === 1'b1 && done === 1'b0 &&
				wr_credit === 1'b0 && rd_valid === 1'b0)
			else log_error($sformatf("not idle: scl %b sda %b done %b credit %b rd %b",
				scl, sda, done, wr_credit, rd_valid));
		end
	endtask

	task automatic issue_cmd(input logic rnw, input logic [7:0] reg_addr, input int n);
		cmd.rnw      = rnw;
		cmd.dev_addr = DEV_ADDR;
		cmd.reg_addr = reg_addr;
		cmd.length   = n[`I2C_LEN_W-1:0];
		cmd_valid    = 1'b1;
		@(negedge clk);
		cmd_valid = 1'b0;
	endtask

	// stop must already be on the bus when done shows up
	task automatic end_transfer(input int stops0, input int dones0);
		wait_done();
		if (timeout_cnt != 0)
			return;
		assert (slave_i.stop_cnt - stops0 == 1)
		else log_error($sformatf("%0d stops before done", slave_i.stop_cnt - stops0));
		@(negedge clk);
		assert (done_seen - dones0 == 1)
		else log_error($sformatf("%0d done pulses", done_seen - dones0));
		check_memory();
	endtask

	task automatic write_regs(input logic [7:0] reg_addr, input int n, input logic stall);
		int credits0;
		int dones0;
		int stops0;
		int rises0;
		int limit;
		if (timeout_cnt != 0)
			return;
		credits0   = credit_seen;
		dones0     = done_seen;
		stops0     = slave_i.stop_cnt;
		shadow_ptr = reg_addr;
		issue_cmd(1'b0, reg_addr, n);
		for (int i = 0; i < n; i++) begin
			wait_credit();
			if (timeout_cnt != 0)
				return;
			rises0 = scl_rises;
			if (stall)
				repeat (int'(rand_byte()) * 8) @(negedge clk);
			// symbols the master may still clock before this byte is needed
			limit = (i == 0) ? 18 : 9;
			assert (scl_rises - rises0 <= limit)
			else log_error($sformatf("scl rose %0d times while byte %0d was due",
				scl_rises - rises0, i));
			wr_data  = ref_byte(1'b1, rand_byte());
			wr_valid = 1'b1;
			@(negedge clk);
			wr_valid = 1'b0;
		end
		end_transfer(stops0, dones0);
		assert (credit_seen - credits0 == n)
		else log_error($sformatf("%0d write credits for %0d bytes", credit_seen - credits0, n));
	endtask

	task automatic read_regs(input logic [7:0] reg_addr, input int n);
		int rd0;
		int credits0;
		int dones0;
		int stops0;
		int acks0;
		int nacks0;
		int rs0;
		int rdaddr0;
		if (timeout_cnt != 0)
			return;
		rd0        = rd_seen;
		credits0   = credit_seen;
		dones0     = done_seen;
		stops0     = slave_i.stop_cnt;
		acks0      = slave_i.acks;
		nacks0     = slave_i.nacks;
		rs0        = slave_i.rstart_cnt;
		rdaddr0    = slave_i.rd_addr_cnt;
		shadow_ptr = reg_addr;
		for (int i = 0; i < n; i++)
			exp_q.push_back(ref_byte(1'b0, 8'h00));
		issue_cmd(1'b1, reg_addr, n);
		end_transfer(stops0, dones0);
		if (timeout_cnt != 0)
			return;
		assert (rd_seen - rd0 == n && exp_q.size() == 0)
		else log_error($sformatf("%0d rd_valid pulses for %0d bytes", rd_seen - rd0, n));
		assert (credit_seen == credits0)
		else log_error($sformatf("%0d write credits during a read", credit_seen - credits0));
		assert (slave_i.acks - acks0 == n - 1 && slave_i.nacks - nacks0 == 1 && slave_i.last_nack)
		else log_error($sformatf("master sent %0d acks and %0d nacks",
			slave_i.acks - acks0, slave_i.nacks - nacks0));
		assert (slave_i.rstart_cnt - rs0 == 1 && slave_i.rd_addr_cnt - rdaddr0 == 1)
		else log_error("repeated start with read address byte missing");
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		cmd       = '0;
		cmd_valid = 1'b0;
		wr_data   = '0;
		wr_valid  = 1'b0;
		rng       = 32'ha984;
		for (int a = 0; a < 256; a++)
			shadow[a] = {a[3:0], a[7:4]} ^ 8'h5a;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		check_idle();
		addr = rand_byte();
		write_regs(addr, 1, 1'b0);
		read_regs(addr, 1);
		for (int i = 0; i < 4; i++) begin
			addr = rand_byte();
			len  = 2 + int'(rand_byte()) % 7;
			write_regs(addr, len, 1'b1);
			// one byte either side of the written block
			read_regs(addr - 8'd1, len + 2);
		end

		$display("value errors: %0d, timeouts: %0d", err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: verification/i2c_slave_model.sv
module i2c_slave_model #(
	parameter logic [6:0] DEV_ADDR = 7'h2a
) (
	input logic scl,
	inout wire  sda
);

	timeunit 1ns;
	timeprecision 1ns;

	typedef enum {PH_IDLE, PH_ADDR, PH_REG, PH_WRITE, PH_READ} phase_e;

	logic [7:0] mem [256];
	logic [7:0] ptr = 8'h00;
	logic [7:0] shreg = 8'h00;
	int         bit_cnt = 0;
	phase_e     phase = PH_IDLE;
	logic       in_xfer = 1'b0;
	logic       second_addr = 1'b0;
	logic       rd_started = 1'b0;
	logic       drive_low = 1'b0;
	logic       last_nack = 1'b0;
	int         stop_cnt = 0;
	int         rstart_cnt = 0;
	int         rd_addr_cnt = 0;
	int         acks = 0;
	int         nacks = 0;

	assign sda = drive_low ? 1'b0 : 1'bz;

	initial begin
		for (int a = 0; a < 256; a++)
			mem[a] = {a[3:0], a[7:4]} ^ 8'h5a;
	end

	// start, or repeated start inside a transfer
	always @(negedge sda) begin
		if (scl === 1'b1) begin
			if (in_xfer)
				rstart_cnt++;
			second_addr = in_xfer;
			in_xfer     = 1'b1;
			phase       = PH_ADDR;
			bit_cnt     = 0;
			rd_started  = 1'b0;
		end
	end

	always @(posedge sda) begin
		if (scl === 1'b1) begin
			stop_cnt++;
			in_xfer = 1'b0;
			phase   = PH_IDLE;
		end
	end

	always @(posedge scl) begin
		if (phase != PH_IDLE && bit_cnt < 8) begin
			shreg = {shreg[6:0], sda};
			bit_cnt++;
			if (bit_cnt == 8) begin
				case (phase)
					PH_ADDR: begin
						if (second_addr && shreg[0])
							rd_addr_cnt++;
						if (shreg[7:1] != DEV_ADDR)
							phase = PH_IDLE;
						else
							phase = shreg[0] ? PH_READ : PH_REG;
					end
					PH_REG: begin
						ptr   = shreg;
						phase = PH_WRITE;
					end
					PH_WRITE: begin
						mem[ptr] = shreg;
						ptr++;
					end
					default: ptr++;
				endcase
			end
		end else if (phase != PH_IDLE) begin
			// ninth bit, from the master after each read byte
			if (phase == PH_READ && rd_started) begin
				last_nack = (sda !== 1'b0);
				if (last_nack) begin
					nacks++;
					phase = PH_IDLE;
				end else begin
					acks++;
				end
			end
			rd_started = (phase == PH_READ);
			bit_cnt    = 0;
		end
	end

	// sda only changes while scl is low
	always @(negedge scl) begin
		if (phase == PH_IDLE)
			drive_low = 1'b0;
		else if (bit_cnt == 8)
			drive_low = !(phase == PH_READ && rd_started);
		else if (phase == PH_READ && rd_started)
			drive_low = !mem[ptr][7 - bit_cnt];
		else
			drive_low = 1'b0;
	end

endmodule

// File: hdl/i2c_master_top.sv
`include "i2c_defines.svh"

module i2c_master_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  i2c_pkg::cmd_t          cmd,
	input  logic                   cmd_valid,
	input  logic [`I2C_BYTE_W-1:0] wr_data,
	input  logic                   wr_valid,
	output logic                   wr_credit,
	output logic [`I2C_BYTE_W-1:0] rd_data,
	output logic                   rd_valid,
	output logic                   done,
	output logic                   scl,
	inout  wire                    sda
);

	i2c_pkg::bit_req_t      bit_req;
	logic                   req_valid;
	logic                   sym_done;
	logic                   sample;
	logic                   sda_low;
	logic                   load;
	logic [`I2C_BYTE_W-1:0] load_byte;
	logic                   shift;
	logic                   tx_bit;
	logic [`I2C_BYTE_W-1:0] rx_byte;

	// open drain, high comes from the pull-up
	assign sda = sda_low ? 1'b0 : 1'bz;

	i2c_sequencer seq_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.wr_data   (wr_data),
		.wr_valid  (wr_valid),
		.sym_done  (sym_done),
		.rx_byte   (rx_byte),
		.tx_bit    (tx_bit),
		.wr_credit (wr_credit),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid),
		.done      (done),
		.bit_req   (bit_req),
		.req_valid (req_valid),
		.load      (load),
		.load_byte (load_byte),
		.shift     (shift)
	);

	i2c_bit_engine engine_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.bit_req   (bit_req),
		.req_valid (req_valid),
		.sda_in    (sda),
		.busy      (),
		.sym_done  (sym_done),
		.sample    (sample),
		.scl       (scl),
		.sda_low   (sda_low)
	);

	i2c_byte_shifter shifter_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.load      (load),
		.load_byte (load_byte),
		.shift     (shift),
		.sample    (sample),
		.tx_bit    (tx_bit),
		.rx_byte   (rx_byte)
	);

endmodule

// File: hdl/i2c_sequencer.sv
`include "i2c_defines.svh"

module i2c_sequencer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  i2c_pkg::cmd_t          cmd,
	input  logic                   cmd_valid,
	input  logic [`I2C_BYTE_W-1:0] wr_data,
	input  logic                   wr_valid,
	input  logic                   sym_done,
	input  logic [`I2C_BYTE_W-1:0] rx_byte,
	input  logic                   tx_bit,
	output logic                   wr_credit,
	output logic [`I2C_BYTE_W-1:0] rd_data,
	output logic                   rd_valid,
	output logic                   done,
	output i2c_pkg::bit_req_t      bit_req,
	output logic                   req_valid,
	output logic                   load,
	output logic [`I2C_BYTE_W-1:0] load_byte,
	output logic                   shift
);

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_START,
		ST_ADDR,
		ST_ACK_ADDR,
		ST_REG,
		ST_ACK_REG,
		ST_WLOAD,
		ST_WDATA,
		ST_ACK_WDATA,
		ST_RSTART,
		ST_RADDR,
		ST_ACK_RADDR,
		ST_RDATA,
		ST_MACK,
		ST_STOP
	} state_e;

	state_e                 state;
	i2c_pkg::cmd_t          cmd_q;
	i2c_pkg::addr_byte_u    addr_byte;
	logic [`I2C_BYTE_W-1:0] buf_data;
	logic                   buf_full;
	logic                   pend;
	logic [2:0]             bit_cnt;
	logic [`I2C_LEN_W-1:0]  byte_cnt;
	logic [`I2C_LEN_W-1:0]  credit_cnt;
	logic [`I2C_LEN_W-1:0]  len_eff;
	logic                   accept;
	logic                   in_byte;
	logic                   byte_end;
	logic                   last_byte;
	logic                   data_due;
	logic                   wload;

	assign len_eff   = (cmd.length == '0) ? `I2C_LEN_W'(1) : cmd.length;
	assign accept    = cmd_valid && (state == ST_IDLE);
	assign in_byte   = state inside {ST_ADDR, ST_REG, ST_WDATA, ST_RADDR, ST_RDATA};
	assign byte_end  = sym_done && in_byte && (bit_cnt == 3'd7);
	assign last_byte = (byte_cnt == `I2C_LEN_W'(1));

	// next write byte wanted in the shifter
	assign data_due = (state == ST_WLOAD) ||
		(sym_done && !cmd_q.rnw && (state == ST_ACK_REG)) ||
		(sym_done && (state == ST_ACK_WDATA) && !last_byte);
	assign wload = data_due && buf_full;

	assign shift     = sym_done && in_byte;
	assign load      = wload || (sym_done && (state inside {ST_START, ST_RSTART, ST_ACK_ADDR}));
	assign req_valid = !pend && !(state inside {ST_IDLE, ST_WLOAD});
	assign rd_data   = rx_byte;

	// second address byte carries the read flag
	always_comb begin
		addr_byte.fields.dev_addr = cmd_q.dev_addr;
		addr_byte.fields.rnw      = (state == ST_RSTART);
	end

	always_comb begin
		case (state)
			ST_START, ST_RSTART: load_byte = addr_byte.raw;
			ST_ACK_ADDR:         load_byte = cmd_q.reg_addr;
			default:             load_byte = buf_data;
		endcase
	end

	always_comb begin
		bit_req.sym   = i2c_pkg::SYM_BIT;
		bit_req.level = 1'b1;
		case (state)
			ST_START, ST_RSTART: bit_req.sym = i2c_pkg::SYM_START;
			ST_STOP: begin
				bit_req.sym   = i2c_pkg::SYM_STOP;
				bit_req.level = 1'b0;
			end
			ST_ADDR, ST_REG, ST_WDATA, ST_RADDR: bit_req.level = tx_bit;
			// nack on the final byte
			ST_MACK: bit_req.level = last_byte;
			default: ;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// transfer fsm
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			pend       <= 1'b0;
			bit_cnt    <= 3'd0;
			byte_cnt   <= '0;
			credit_cnt <= '0;
			buf_full   <= 1'b0;
			wr_credit  <= 1'b0;
			rd_valid   <= 1'b0;
			done       <= 1'b0;
		end else begin
			wr_credit <= 1'b0;
			rd_valid  <= 1'b0;
			done      <= 1'b0;
			if (req_valid)
				pend <= 1'b1;
			else if (sym_done)
				pend <= 1'b0;
			// wraps to 0 after the eighth bit
			if (shift)
				bit_cnt <= bit_cnt + 3'd1;
			if (wload)
				buf_full <= 1'b0;
			if (wr_valid)
				buf_full <= 1'b1;
			if (wload && (credit_cnt != '0)) begin
				wr_credit  <= 1'b1;
				credit_cnt <= credit_cnt - 1'b1;
			end
			case (state)
				ST_IDLE: if (accept) begin
					state      <= ST_START;
					byte_cnt   <= len_eff;
					credit_cnt <= cmd.rnw ? '0 : len_eff - 1'b1;
					wr_credit  <= !cmd.rnw;
				end
				ST_START:    if (sym_done) state <= ST_ADDR;
				ST_ADDR:     if (byte_end) state <= ST_ACK_ADDR;
				ST_ACK_ADDR: if (sym_done) state <= ST_REG;
				ST_REG:      if (byte_end) state <= ST_ACK_REG;
				ST_ACK_REG: if (sym_done) begin
					if (cmd_q.rnw)
						state <= ST_RSTART;
					else
						state <= buf_full ? ST_WDATA : ST_WLOAD;
				end
				// scl stays low here until the host delivers
				ST_WLOAD: if (buf_full) state <= ST_WDATA;
				ST_WDATA: if (byte_end) state <= ST_ACK_WDATA;
				ST_ACK_WDATA: if (sym_done) begin
					if (last_byte) begin
						state <= ST_STOP;
					end else begin
						byte_cnt <= byte_cnt - 1'b1;
						state    <= buf_full ? ST_WDATA : ST_WLOAD;
					end
				end
				ST_RSTART:    if (sym_done) state <= ST_RADDR;
				ST_RADDR:     if (byte_end) state <= ST_ACK_RADDR;
				ST_ACK_RADDR: if (sym_done) state <= ST_RDATA;
				ST_RDATA: if (byte_end) begin
					rd_valid <= 1'b1;
					state    <= ST_MACK;
				end
				ST_MACK: if (sym_done) begin
					if (last_byte) begin
						state <= ST_STOP;
					end else begin
						byte_cnt <= byte_cnt - 1'b1;
						state    <= ST_RDATA;
					end
				end
				ST_STOP: if (sym_done) begin
					done  <= 1'b1;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			cmd_q <= cmd;
		if (wr_valid)
			buf_data <= wr_data;
	end

endmodule

// File: hdl/i2c_bit_engine.sv
`include "i2c_defines.svh"

module i2c_bit_engine (
	input  logic              clk,
	input  logic              rst_n,
	input  i2c_pkg::bit_req_t bit_req,
	input  logic              req_valid,
	input  logic              sda_in,
	output logic              busy,
	output logic              sym_done,
	output logic              sample,
	output logic              scl,
	output logic              sda_low
);

	localparam logic [`I2C_QCNT_W-1:0] QUARTER_LAST = `I2C_QCNT_W'(`I2C_QUARTER_CLKS - 1);

	logic [`I2C_QCNT_W-1:0] qcnt;
	logic [1:0]             qidx;
	i2c_pkg::bit_req_t      req_q;
	logic                   accept;
	logic                   q_end;
	logic                   advance;
	i2c_pkg::bit_req_t      wave_req;
	logic [1:0]             wave_q;
	logic                   wave_scl;
	logic                   wave_sda;

	assign accept   = req_valid && !busy;
	assign q_end    = busy && (qcnt == QUARTER_LAST);
	assign sym_done = q_end && (qidx == 2'd3);
	assign advance  = q_end && (qidx != 2'd3);

	// levels for the quarter about to begin
	assign wave_req = accept ? bit_req : req_q;
	assign wave_q   = accept ? 2'd0 : qidx + 2'd1;

	always_comb begin
		case (wave_req.sym)
			// scl 1 1 0 0, sda 1 0 0 0
			i2c_pkg::SYM_START: begin
				wave_scl = !wave_q[1];
				wave_sda = (wave_q == 2'd0);
			end
			// scl 0 1 1 1, sda 0 0 1 1
			i2c_pkg::SYM_STOP: begin
				wave_scl = (wave_q != 2'd0);
				wave_sda = wave_q[1];
			end
			default: begin
				wave_scl = (wave_q == 2'd1) || (wave_q == 2'd2);
				wave_sda = wave_req.level;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			qcnt    <= '0;
			qidx    <= 2'd0;
			scl     <= 1'b1;
			sda_low <= 1'b0;
		end else begin
			if (accept) begin
				busy <= 1'b1;
				qcnt <= '0;
				qidx <= 2'd0;
			end else if (q_end) begin
				qcnt <= '0;
				qidx <= qidx + 2'd1;
				busy <= (qidx != 2'd3);
			end else if (busy) begin
				qcnt <= qcnt + 1'b1;
			end
			// lines hold between symbols
			if (accept || advance) begin
				scl     <= wave_scl;
				sda_low <= !wave_sda;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			req_q <= bit_req;
		// middle of the scl high phase
		if (q_end && (qidx == 2'd1))
			sample <= sda_in;
	end

endmodule

// File: hdl/i2c_byte_shifter.sv
`include "i2c_defines.svh"

module i2c_byte_shifter (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   load,
	input  logic [`I2C_BYTE_W-1:0] load_byte,
	input  logic                   shift,
	input  logic                   sample,
	output logic                   tx_bit,
	output logic [`I2C_BYTE_W-1:0] rx_byte
);

	logic [`I2C_BYTE_W-1:0] sh;

	// msb first in both directions
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sh <= '0;
		end else if (load) begin
			sh <= load_byte;
		end else if (shift) begin
			sh <= {sh[`I2C_BYTE_W-2:0], sample};
		end
	end

	assign tx_bit  = sh[`I2C_BYTE_W-1];
	assign rx_byte = sh;

endmodule

// File: hdl/i2c_pkg.sv
`include "i2c_defines.svh"

package i2c_pkg;

	// one register access
	typedef struct packed {
		logic                   rnw;
		logic [6:0]             dev_addr;
		logic [`I2C_BYTE_W-1:0] reg_addr;
		logic [`I2C_LEN_W-1:0]  length;
	} cmd_t;

	// address byte after start
	// read/write flag sits in the lsb
	typedef union packed {
		logic [`I2C_BYTE_W-1:0] raw;
		struct packed {
			logic [6:0] dev_addr;
			logic       rnw;
		} fields;
	} addr_byte_u;

	//////////////////////////////////////////////////////////////////////
	// bus symbols
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		SYM_START,
		SYM_STOP,
		SYM_BIT
	} bus_sym_e;

	// level is only looked at for SYM_BIT, 1 releases sda
	typedef struct packed {
		bus_sym_e sym;
		logic     level;
	} bit_req_t;

endpackage

// File: hdl/i2c_defines.svh
`ifndef I2C_DEFINES_SVH
`define I2C_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// bus timing
//////////////////////////////////////////////////////////////////////

// system clocks per quarter bit
`define I2C_QUARTER_CLKS 32

// quarter counter must hold I2C_QUARTER_CLKS-1
`define I2C_QCNT_W 5

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////

`define I2C_BYTE_W 8

// byte count per transfer, 0 acts as 1
`define I2C_LEN_W 5

`endif
